/* bundle_buffer.sv */
`timescale 1ns/1ps

module bundle_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  hdc_cmd_pkg::ctr_ctrl_t    ctrl,
    input  hdc_cfg_pkg::core_bank_t   core_results,
    input  hdc_cmd_pkg::stream_req_t  sreq,
    output hdc_cmd_pkg::stream_beat_t beat
);
    import hdc_cfg_pkg::*;

    // bundled hypervector, one sign per dimension
    hv_t sign_vec;

    // registered beat
    logic              beat_valid_q;
    logic [beat_w-1:0] beat_data_q;

    // counter array, one instance per dimension
    for (genvar d = 0; d < hv_dim; d++) begin : g_dim

        // this dimension's bit from each core, core 0 in bit 0
        core_mask_t dim_bits;

        for (genvar c = 0; c < num_cores; c++) begin : g_core
            assign dim_bits[c] = core_results[c][d];
        end

        dim_counter dim_counter_inst (
            .clk  (clk),
            .rst  (rst),
            .ctrl (ctrl),
            .bits (dim_bits),
            .sign (sign_vec[d])
        );
    end

    // valid follows the request one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_valid_q <= 1'b0;
        end else begin
            beat_valid_q <= sreq.valid;
        end
    end

    // payload, no reset
    // index i takes sign bits i*beat_w up to i*beat_w+beat_w-1
    always_ff @(posedge clk) begin
        if (sreq.valid) begin
            beat_data_q <= sign_vec[sreq.index*beat_w +: beat_w];
        end
    end

    assign beat = '{valid: beat_valid_q, data: beat_data_q};

endmodule

/* bundle_sequencer.sv */
`timescale 1ns/1ps

module bundle_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_valid,
    input  hdc_cmd_pkg::hv_cmd_t     cmd,
    output hdc_cmd_pkg::ctr_ctrl_t   ctrl,
    output hdc_cmd_pkg::stream_req_t sreq,
    output logic                     busy
);
    import hdc_cfg_pkg::*;
    import hdc_cmd_pkg::*;

    // read burst state
    logic      busy_q;
    beat_idx_t idx_q;

    // commands are dropped for the whole burst
    logic accept;
    logic start_read;
    logic last_beat;

    assign accept     = cmd_valid && !busy_q;
    assign start_read = accept && (cmd.op == op_read);
    assign last_beat  = (idx_q == beat_idx_t'(num_beats - 1));

    // opcode decode, same cycle as the strobe
    always_comb begin
        ctrl = '0;
        if (accept) begin
            // operands pass through, strobes from the opcode
            ctrl.sub       = cmd.sub;
            ctrl.core_mask = cmd.core_mask;
            ctrl.slot      = cmd.slot;
            case (cmd.op)
                op_clear: ctrl.clear = 1'b1;
                op_accum: ctrl.accum = 1'b1;
                op_save:  ctrl.save  = 1'b1;
                op_load:  ctrl.load  = 1'b1;
                // read touches no counter
                default:  ctrl.clear = 1'b0;
            endcase
        end
    end

    // beat counter: 0..num_beats-1 on consecutive cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (busy_q) begin
            idx_q <= idx_q + 1'b1;
            // free again the cycle after the last index
            if (last_beat) begin
                busy_q <= 1'b0;
            end
        end else if (start_read) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end
    end

    // one request per busy cycle
    assign sreq = '{valid: busy_q, index: idx_q};
    assign busy = busy_q;

endmodule

/* dim_counter.sv */
`timescale 1ns/1ps

module dim_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  hdc_cmd_pkg::ctr_ctrl_t  ctrl,
    input  hdc_cfg_pkg::core_mask_t bits,
    output logic                    sign
);
    import hdc_cfg_pkg::*;

    // live count and its snapshots
    cnt_t count_q;
    cnt_t slots_q [num_slots];

    // one extra bit so a single overflow is visible
    logic signed [cnt_w:0] delta;
    logic signed [cnt_w:0] sum_wide;
    logic                  ovf;
    cnt_t                  count_sat;

    // net contribution of the selected cores, at most +-num_cores
    always_comb begin
        delta = '0;
        for (int c = 0; c < num_cores; c++) begin
            if (ctrl.core_mask[c]) begin
                // bit 1 votes up, bit 0 votes down
                if (bits[c]) begin
                    delta = delta + 1;
                end else begin
                    delta = delta - 1;
                end
            end
        end
        // subtract reverses every vote
        if (ctrl.sub) begin
            delta = -delta;
        end
    end

    // add in cnt_w+1 bits, then clamp
    always_comb begin
        sum_wide = {count_q[cnt_w-1], count_q} + delta;
        // top two bits disagree -> result left the cnt_w range
        ovf = sum_wide[cnt_w] ^ sum_wide[cnt_w-1];
        if (!ovf) begin
            count_sat = sum_wide[cnt_w-1:0];
        end else if (sum_wide[cnt_w]) begin
            // went below the minimum
            count_sat = {1'b1, {(cnt_w-1){1'b0}}};
        end else begin
            // went above the maximum
            count_sat = {1'b0, {(cnt_w-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
            for (int s = 0; s < num_slots; s++) begin
                slots_q[s] <= '0;
            end
        end else begin
            // at most one of these per cycle from the sequencer
            if (ctrl.clear) begin
                count_q <= '0;
            end else if (ctrl.load) begin
                count_q <= slots_q[ctrl.slot];
            end else if (ctrl.accum) begin
                count_q <= count_sat;
            end
            // snapshot takes the count before this edge
            // clear never touches the slots
            if (ctrl.save) begin
                slots_q[ctrl.slot] <= count_q;
            end
        end
    end

    // strictly positive -> 1, tie or negative -> 0
    assign sign = !count_q[cnt_w-1] && (count_q != '0);

endmodule

/* hdc_cfg_pkg.sv */
package hdc_cfg_pkg;

    // hypervector width, kept small for simulation
    localparam int hv_dim = 256;

    // compute cores feeding the bundler
    localparam int num_cores = 4;

    // per-dimension count, signed, saturating
    localparam int cnt_w = 8;

    // snapshot slots for the full counter state
    localparam int num_slots = 4;

    // output stream geometry
    localparam int beat_w = 64;
    localparam int num_beats = hv_dim / beat_w;

    // one binary hypervector
    typedef logic [hv_dim-1:0] hv_t;

    // one hypervector per core, core 0 in the low slice
    typedef hv_t [num_cores-1:0] core_bank_t;

    // core select, one bit per core
    typedef logic [num_cores-1:0] core_mask_t;

    // signed running count of a single dimension
    typedef logic signed [cnt_w-1:0] cnt_t;

    typedef logic [$clog2(num_slots)-1:0] slot_t;
    typedef logic [$clog2(num_beats)-1:0] beat_idx_t;

endpackage

/* hdc_cmd_pkg.sv */
package hdc_cmd_pkg;

    // command opcodes, values 5..7 are unused and ignored
    typedef enum logic [2:0] {
        op_clear,
        op_accum,
        op_save,
        op_load,
        op_read
    } hv_op_e;

    // command word from the source, valid for one cycle
    typedef struct packed {
        hv_op_e                  op;
        hdc_cfg_pkg::core_mask_t core_mask;
        // negate every contribution of an accumulate
        logic                    sub;
        hdc_cfg_pkg::slot_t      slot;
    } hv_cmd_t;

    // per-cycle counter controls, sequencer to buffer
    // all strobes here are high for a single cycle
    typedef struct packed {
        logic                    clear;
        logic                    accum;
        logic                    sub;
        hdc_cfg_pkg::core_mask_t core_mask;
        logic                    save;
        logic                    load;
        hdc_cfg_pkg::slot_t      slot;
    } ctr_ctrl_t;

    // beat request during a read burst
    typedef struct packed {
        logic                   valid;
        hdc_cfg_pkg::beat_idx_t index;
    } stream_req_t;

    // outgoing stream beat, no ready
    typedef struct packed {
        logic                          valid;
        logic [hdc_cfg_pkg::beat_w-1:0] data;
    } stream_beat_t;

endpackage

/* hv_bundle_top.sv */
`timescale 1ns/1ps

module hv_bundle_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cmd_valid,
    input  hdc_cmd_pkg::hv_cmd_t      cmd,
    input  hdc_cfg_pkg::core_bank_t   core_results,
    output hdc_cmd_pkg::stream_beat_t beat,
    output logic                      busy
);
    import hdc_cmd_pkg::*;

    // sequencer -> buffer
    ctr_ctrl_t   ctrl;
    stream_req_t sreq;

    // command decode and read burst
    bundle_sequencer bundle_sequencer_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .ctrl      (ctrl),
        .sreq      (sreq),
        .busy      (busy)
    );

    // counters and beat select
    // core results sampled on the accumulate edge
    bundle_buffer bundle_buffer_inst (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .core_results (core_results),
        .sreq         (sreq),
        .beat         (beat)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, pass decided from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_hv_bundle \
    -f sources.f -Mdir obj_dir -o sim_tb || { echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

/* sources.f */
hdc_cfg_pkg.sv
hdc_cmd_pkg.sv
dim_counter.sv
bundle_buffer.sv
bundle_sequencer.sv
hv_bundle_top.sv
tb_hv_bundle.sv

/* tb_hv_bundle.sv */
`timescale 1ns/1ps

module tb_hv_bundle;
    import hdc_cfg_pkg::*;
    import hdc_cmd_pkg::*;

    // the full command sequence stays well below half of this
    localparam int max_cycles = 4000;

    // signed limits of one counter
    localparam int cnt_max = (1 << (cnt_w - 1)) - 1;
    localparam int cnt_min = -(1 << (cnt_w - 1));

    logic         clk;
    logic         rst;
    logic         cmd_valid;
    hv_cmd_t      cmd;
    core_bank_t   core_results;
    stream_beat_t beat;
    logic         busy;

    // reference counts and snapshots
    int model_cnt [hv_dim];
    int model_slot [num_slots][hv_dim];

    // expected beats, with the cycle each one is due
    logic [beat_w-1:0] exp_data [$];
    int                exp_cycle [$];

    // cycles of the latest burst in which busy must be high
    int busy_from = 0;
    int busy_to   = -1;

    // vectors kept for the undo test
    core_bank_t saved_bank [5];
    core_mask_t saved_mask [5];

    int cycle_cnt = 0;

    hv_bundle_top hv_bundle_top_inst (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .core_results (core_results),
        .beat         (beat),
        .busy         (busy)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    // edge count, also the watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            fail_run("timeout: the stimulus did not finish within the cycle limit");
        end
    end

    function automatic int sat_count(input int value);
        if (value > cnt_max) begin
            return cnt_max;
        end else if (value < cnt_min) begin
            return cnt_min;
        end
        return value;
    endfunction

    // expected beat from the model signs
    function automatic logic [beat_w-1:0] ref_beat(input int index);
        logic [beat_w-1:0] b;
        for (int i = 0; i < beat_w; i++) begin
            // strictly positive reads as 1, a tie as 0
            b[i] = (model_cnt[index * beat_w + i] > 0);
        end
        return b;
    endfunction

    // reference update for one accepted command
    task automatic model_apply(input hv_cmd_t c, input core_bank_t bank);
        int delta;
        for (int d = 0; d < hv_dim; d++) begin
            case (c.op)
                op_clear: model_cnt[d] = 0;
                op_accum: begin
                    delta = 0;
                    for (int k = 0; k < num_cores; k++) begin
                        if (c.core_mask[k]) begin
                            delta = bank[k][d] ? delta + 1 : delta - 1;
                        end
                    end
                    if (c.sub) begin
                        delta = -delta;
                    end
                    model_cnt[d] = sat_count(model_cnt[d] + delta);
                end
                op_save: model_slot[c.slot][d] = model_cnt[d];
                op_load: model_cnt[d] = model_slot[c.slot][d];
                // read changes no count
                default: ;
            endcase
        end
    endtask

    task automatic randomize_cores();
        for (int c = 0; c < num_cores; c++) begin
            for (int w = 0; w < hv_dim / 32; w++) begin
                core_results[c][w * 32 +: 32] = $urandom();
            end
        end
    endtask

    // one accepted command, waits out any burst first
    task automatic send_cmd(input hv_op_e op, input core_mask_t mask, input logic sub,
                            input slot_t slot);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        cmd = '{op: op, core_mask: mask, sub: sub, slot: slot};
        cmd_valid = 1'b1;
        model_apply(cmd, core_results);
        if (op == op_read) begin
            // busy from the next cycle, one cycle per beat
            busy_from = cycle_cnt + 1;
            busy_to   = cycle_cnt + num_beats;
            // beat k due 2 + k cycles after the strobe cycle
            for (int k = 0; k < num_beats; k++) begin
                exp_data.push_back(ref_beat(k));
                exp_cycle.push_back(cycle_cnt + 2 + k);
            end
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // strobe during a burst, model left alone
    task automatic drop_cmd(input hv_op_e op, input core_mask_t mask);
        assert (busy) else begin
            fail_run("a command meant to be dropped was issued while the DUT was idle");
        end
        cmd = '{op: op, core_mask: mask, sub: 1'b0, slot: '0};
        cmd_valid = 1'b1;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // busy window of each read burst
    always @(negedge clk) begin
        if (!rst) begin
            assert (busy == (cycle_cnt >= busy_from && cycle_cnt <= busy_to)) else begin
                fail_run($sformatf("FAILED at %0t: busy %b in cycle %0d",
                    $time, busy, cycle_cnt));
            end
        end
    end

    // beat checker
    always @(negedge clk) begin
        if (!rst && beat.valid) begin
            assert (exp_data.size() != 0) else begin
                fail_run("a beat arrived while no beat was expected");
            end
            assert (beat.data == exp_data[0]) else begin
                fail_run($sformatf("FAILED at %0t: beat data %h, expected %h",
                    $time, beat.data, exp_data[0]));
            end
            assert (cycle_cnt == exp_cycle[0]) else begin
                fail_run($sformatf("FAILED at %0t: beat in cycle %0d, expected cycle %0d",
                    $time, cycle_cnt, exp_cycle[0]));
            end
            void'(exp_data.pop_front());
            void'(exp_cycle.pop_front());
        end
    end

    initial begin
        void'($urandom(23072));
        clk          = 1'b0;
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        core_results = '0;
        for (int d = 0; d < hv_dim; d++) begin
            model_cnt[d] = 0;
            for (int s = 0; s < num_slots; s++) begin
                model_slot[s][d] = 0;
            end
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // fresh state reads as zeros, first beat 2 cycles on
        send_cmd(op_read, '0, 1'b0, '0);

        // random bundling, reads in between
        for (int i = 0; i < 300; i++) begin
            randomize_cores();
            send_cmd(op_accum, core_mask_t'($urandom()), ($urandom() % 4) == 0, '0);
            if (i % 6 == 5) begin
                send_cmd(op_read, '0, 1'b0, '0);
            end
        end

        // adds then matching subtracts, back to all ties
        send_cmd(op_clear, '0, 1'b0, '0);
        for (int i = 0; i < 5; i++) begin
            randomize_cores();
            saved_bank[i] = core_results;
            saved_mask[i] = core_mask_t'($urandom());
            send_cmd(op_accum, saved_mask[i], 1'b0, '0);
        end
        send_cmd(op_read, '0, 1'b0, '0);
        for (int i = 0; i < 5; i++) begin
            core_results = saved_bank[i];
            send_cmd(op_accum, saved_mask[i], 1'b1, '0);
        end
        send_cmd(op_read, '0, 1'b0, '0);

        // drive into saturation, then pull back past zero
        send_cmd(op_clear, '0, 1'b0, '0);
        randomize_cores();
        for (int i = 0; i < 40; i++) begin
            send_cmd(op_accum, '1, 1'b0, '0);
        end
        send_cmd(op_read, '0, 1'b0, '0);
        core_results = ~core_results;
        for (int i = 0; i < 35; i++) begin
            send_cmd(op_accum, '1, 1'b0, '0);
        end
        send_cmd(op_read, '0, 1'b0, '0);
        for (int i = 0; i < 60; i++) begin
            send_cmd(op_accum, '1, 1'b0, '0);
        end
        send_cmd(op_read, '0, 1'b0, '0);

        // snapshot, wipe, restore
        send_cmd(op_clear, '0, 1'b0, '0);
        for (int i = 0; i < 6; i++) begin
            randomize_cores();
            send_cmd(op_accum, core_mask_t'($urandom()), 1'b0, '0);
        end
        send_cmd(op_save, '0, 1'b0, slot_t'(2));
        send_cmd(op_read, '0, 1'b0, '0);
        send_cmd(op_clear, '0, 1'b0, '0);
        send_cmd(op_read, '0, 1'b0, '0);
        for (int i = 0; i < 4; i++) begin
            randomize_cores();
            send_cmd(op_accum, core_mask_t'($urandom()), 1'b0, '0);
        end
        send_cmd(op_save, '0, 1'b0, slot_t'(1));
        send_cmd(op_load, '0, 1'b0, slot_t'(2));
        send_cmd(op_read, '0, 1'b0, '0);
        // slots survive a clear
        send_cmd(op_clear, '0, 1'b0, '0);
        send_cmd(op_load, '0, 1'b0, slot_t'(1));
        send_cmd(op_read, '0, 1'b0, '0);

        // strobes inside a burst are dropped
        randomize_cores();
        send_cmd(op_accum, '1, 1'b0, '0);
        send_cmd(op_read, '0, 1'b0, '0);
        drop_cmd(op_clear, '0);
        randomize_cores();
        drop_cmd(op_accum, '1);
        send_cmd(op_read, '0, 1'b0, '0);

        // drain the last burst
        while (busy) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        if (exp_data.size() != 0) begin
            fail_run("the run ended with expected beats that never arrived");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
